/* audio/i2s_codec.sv */
// ==========================================================================
// I2S codec serializer: bit and frame clocks from cpu_clk, DAC samples
// shifted out MSB first one bit after each lrclk edge, left ADC shifted in
// Clocks and counters sit at the start of a left half while disabled
// ==========================================================================

`default_nettype none

module i2s_codec #(
	parameter int BCLK_DIV = 2
) (
	input  wire               cpu_clk,
	input  wire               rst,
	input  wire               tx_en_i,
	input  wire               rx_en_i,
	input  sys_pkg::sample_t  dac_left_i,
	input  sys_pkg::sample_t  dac_right_i,
	input  wire               adc_i,
	output logic              bclk_o,
	output logic              lrclk_o,
	output logic              dac_o,
	output sys_pkg::sample_t  adc_sample_o,
	output logic              adc_valid_o
);

	localparam int DIV_W = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;

	logic [DIV_W-1:0] div_q;
	logic             bclk_q;
	logic [5:0]       bit_q;
	logic [5:0]       bit_nx;
	logic [31:0]      sr_q;
	logic [14:0]      sh_q;
	logic             tx_d;
	logic             rx_d;
	logic             en;
	logic             restart;
	logic             tick;
	logic             fall;
	logic             rise;
	logic             in_slot;

	assign en      = tx_en_i | rx_en_i;
	assign restart = (tx_en_i & ~tx_d) | (rx_en_i & ~rx_d);
	assign tick    = (div_q == DIV_W'(BCLK_DIV - 1));
	assign fall    = en && tick && bclk_q;
	assign rise    = en && tick && !bclk_q;
	assign bit_nx  = bit_q + 6'd1;

	// ======================================================================
	// Bit clock divider and frame position
	// ======================================================================

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			div_q  <= '0;
			bclk_q <= 1'b0;
			bit_q  <= '0;
			tx_d   <= 1'b0;
			rx_d   <= 1'b0;
		end else begin
			tx_d <= tx_en_i;
			rx_d <= rx_en_i;
			if (!en || restart) begin
				div_q  <= '0;
				bclk_q <= 1'b0;
				bit_q  <= '0;
			end else begin
				if (tick) begin
					div_q  <= '0;
					bclk_q <= ~bclk_q;
				end else begin
					div_q <= div_q + 1'b1;
				end
				// A new bit period begins on each falling edge
				if (fall)
					bit_q <= bit_nx;
			end
		end
	end

	// ======================================================================
	// DAC shift-out, slot 0 of each half is blank
	// ======================================================================

	always_ff @(posedge cpu_clk) begin
		if (!en || restart) begin
			sr_q <= {1'b0, dac_left_i, 15'h0000};
		end else if (fall) begin
			if (bit_nx[4:0] == 5'd0)
				sr_q <= {1'b0, bit_nx[5] ? dac_right_i : dac_left_i, 15'h0000};
			else
				sr_q <= {sr_q[30:0], 1'b0};
		end
	end

	// ======================================================================
	// ADC shift-in, left half only, slots 1 to 16
	// ======================================================================

	assign in_slot = rx_en_i && rise && !bit_q[5] &&
	                 (bit_q[4:0] >= 5'd1) && (bit_q[4:0] <= 5'd16);

	always_ff @(posedge cpu_clk) begin
		if (in_slot)
			sh_q <= {sh_q[13:0], adc_i};
		if (in_slot && bit_q[4:0] == 5'd16)
			adc_sample_o <= {sh_q, adc_i};
	end

	always_ff @(posedge cpu_clk) begin
		if (rst)
			adc_valid_o <= 1'b0;
		else
			adc_valid_o <= in_slot && (bit_q[4:0] == 5'd16);
	end

	// Pins go low as soon as both enables drop
	assign bclk_o  = en & bclk_q;
	assign lrclk_o = en & bit_q[5];
	assign dac_o   = tx_en_i & sr_q[31];

endmodule

`default_nettype wire

/* common/sys_pkg.sv */
// ==========================================================================
// Shared types and address map for the peripheral bus subsystem
// Every RTL file refers to these through sys_pkg:: scoped names
// ==========================================================================

`default_nettype none

package sys_pkg;

	// Bus widths
	typedef logic [31:0] addr_t;
	typedef logic [15:0] word_t;
	typedef logic [1:0]  sel_t;

	// Signed audio sample as held in the DAC and ADC registers
	typedef logic signed [15:0] sample_t;

	// Wait-state count loaded into the counter
	typedef logic [2:0] wait_cnt_t;

	// Offset inside the I/O register block
	typedef logic [3:0] io_off_t;

	// One bus request, held stable by the master while the strobe is high
	// sel bit 1 is the upper byte lane, bit 0 the lower
	typedef struct packed {
		addr_t addr;
		word_t wdata;
		logic  we;
		sel_t  sel;
	} bus_req_t;

	// Decoded target of a cycle
	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_STACK,
		REGION_IO
	} region_e;

	// ======================================================================
	// Address map
	// ======================================================================

	// Stack RAM, upper 12 address bits select it
	localparam addr_t STACK_BASE = 32'hFF40_0000;
	localparam addr_t STACK_MASK = 32'hFFF0_0000;

	// I/O register block, upper 28 address bits select it
	localparam addr_t IO_BASE = 32'hFFDC_0600;
	localparam addr_t IO_MASK = 32'hFFFF_FFF0;

	// Register offsets in the I/O block
	localparam io_off_t IO_LED      = 4'h0;
	localparam io_off_t IO_SW       = 4'h2;
	localparam io_off_t IO_AUD_CTRL = 4'h4;
	localparam io_off_t IO_DAC_L    = 4'h6;
	localparam io_off_t IO_DAC_R    = 4'h8;
	localparam io_off_t IO_ADC      = 4'hA;

endpackage

`default_nettype wire

/* design/bus_sequencer.sv */
// ==========================================================================
// Bus cycle sequencer: decodes the target of each strobe, times the
// access through the wait counter and answers with one acknowledge pulse
// ==========================================================================

`default_nettype none

module bus_sequencer #(
	parameter int STACK_WAIT = 2
) (
	input  wire                 cpu_clk,
	input  wire                 rst,
	input  wire                 bus_stb_i,
	input  sys_pkg::bus_req_t   bus_req_i,
	output logic                bus_ack_o,
	output logic                cnt_load_o,
	output sys_pkg::wait_cnt_t  cnt_value_o,
	input  wire                 cnt_done_i,
	output logic                ram_we_o,
	output logic                ram_re_o,
	output logic                io_we_o,
	output sys_pkg::region_e    region_o
);

	// Counter starts one cycle into WAIT, so load one less
	localparam sys_pkg::wait_cnt_t WAIT_LOAD = sys_pkg::wait_cnt_t'(STACK_WAIT - 1);

	typedef enum logic [2:0] {
		IDLE,
		DECODE,
		WAIT,
		ACK,
		DONE
	} state_e;

	state_e state_q;
	state_e state_d;
	sys_pkg::region_e region_d;
	sys_pkg::region_e region_q;

	// Address decode, only taken into region_q in DECODE
	always_comb begin
		region_d = sys_pkg::REGION_NONE;
		if ((bus_req_i.addr & sys_pkg::STACK_MASK) == sys_pkg::STACK_BASE)
			region_d = sys_pkg::REGION_STACK;
		else if ((bus_req_i.addr & sys_pkg::IO_MASK) == sys_pkg::IO_BASE)
			region_d = sys_pkg::REGION_IO;
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE:   if (bus_stb_i) state_d = DECODE;
			DECODE: state_d = (region_d == sys_pkg::REGION_STACK) ? WAIT : ACK;
			WAIT:   if (cnt_done_i) state_d = ACK;
			ACK:    state_d = DONE;
			// Hold here until the master drops the strobe
			DONE:   if (!bus_stb_i) state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			state_q  <= IDLE;
			region_q <= sys_pkg::REGION_NONE;
		end else begin
			state_q <= state_d;
			if (state_q == DECODE)
				region_q <= region_d;
		end
	end

	// Stack access starts together with the counter load
	assign cnt_load_o  = (state_q == DECODE) && (region_d == sys_pkg::REGION_STACK);
	assign cnt_value_o = WAIT_LOAD;
	assign ram_we_o    = cnt_load_o && bus_req_i.we;
	assign ram_re_o    = cnt_load_o && !bus_req_i.we;

	// Register writes land at the end of the acknowledge cycle
	assign io_we_o   = (state_q == ACK) && (region_q == sys_pkg::REGION_IO) && bus_req_i.we;
	assign bus_ack_o = (state_q == ACK);
	assign region_o  = region_q;

endmodule

`default_nettype wire

/* design/io_regs.sv */
// ==========================================================================
// I/O register block: LEDs, switches, buttons, audio control, DAC
// samples and the captured ADC sample, plus the read mux for the block
// ==========================================================================

`default_nettype none

module io_regs (
	input  wire                cpu_clk,
	input  wire                rst,
	input  wire                we_i,
	input  sys_pkg::region_e   region_i,
	input  sys_pkg::bus_req_t  req_i,
	input  wire  [7:0]         sw_i,
	input  wire  [2:0]         btn_i,
	output logic [7:0]         led_o,
	output logic               tx_en_o,
	output logic               rx_en_o,
	output sys_pkg::sample_t   dac_left_o,
	output sys_pkg::sample_t   dac_right_o,
	input  sys_pkg::sample_t   adc_sample_i,
	input  wire                adc_valid_i,
	output sys_pkg::word_t     rdata_o
);

	sys_pkg::io_off_t off;
	logic [7:0]       led_q;
	sys_pkg::sample_t adc_q;
	logic [23:0]      last_addr;

	assign off = req_i.addr[3:0];

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			led_q       <= '0;
			tx_en_o     <= 1'b0;
			rx_en_o     <= 1'b0;
			dac_left_o  <= '0;
			dac_right_o <= '0;
			adc_q       <= '0;
		end else begin
			if (we_i) begin
				case (off)
					sys_pkg::IO_LED: if (req_i.sel[0]) led_q <= req_i.wdata[7:0];
					sys_pkg::IO_AUD_CTRL: begin
						if (req_i.sel[0]) begin
							tx_en_o <= req_i.wdata[1];
							rx_en_o <= req_i.wdata[0];
						end
					end
					sys_pkg::IO_DAC_L: begin
						if (req_i.sel[1]) dac_left_o[15:8] <= req_i.wdata[15:8];
						if (req_i.sel[0]) dac_left_o[7:0] <= req_i.wdata[7:0];
					end
					sys_pkg::IO_DAC_R: begin
						if (req_i.sel[1]) dac_right_o[15:8] <= req_i.wdata[15:8];
						if (req_i.sel[0]) dac_right_o[7:0] <= req_i.wdata[7:0];
					end
					default: ;
				endcase
			end
			if (adc_valid_i)
				adc_q <= adc_sample_i;
		end
	end

	// Address display source for the buttons
	always_ff @(posedge cpu_clk) begin
		last_addr <= req_i.addr[23:0];
	end

	assign led_o = btn_i[2] ? last_addr[23:16] :
	               btn_i[1] ? last_addr[15:8] :
	               btn_i[0] ? last_addr[7:0] :
	               led_q;

	always_comb begin
		rdata_o = '0;
		if (region_i == sys_pkg::REGION_IO) begin
			case (off)
				sys_pkg::IO_LED:      rdata_o = {8'h00, led_q};
				sys_pkg::IO_SW:       rdata_o = {8'h00, sw_i};
				sys_pkg::IO_AUD_CTRL: rdata_o = {14'h0000, tx_en_o, rx_en_o};
				sys_pkg::IO_DAC_L:    rdata_o = dac_left_o;
				sys_pkg::IO_DAC_R:    rdata_o = dac_right_o;
				sys_pkg::IO_ADC:      rdata_o = adc_q;
				default:              rdata_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* design/periph_sys.sv */
// ==========================================================================
// Peripheral subsystem top level: sequencer, wait counter, stack RAM,
// I/O registers and I2S codec behind one strobe and acknowledge port
// ==========================================================================

`default_nettype none

module periph_sys #(
	parameter int STACK_WAIT   = 2,
	parameter int STACK_ADDR_W = 10,
	parameter int BCLK_DIV     = 2
) (
	input  wire                cpu_clk,
	input  wire                rst,
	input  wire                bus_stb_i,
	input  sys_pkg::bus_req_t  bus_req_i,
	output logic               bus_ack_o,
	output sys_pkg::word_t     bus_rdata_o,
	input  wire  [7:0]         sw_i,
	input  wire  [2:0]         btn_i,
	output logic [7:0]         led_o,
	output logic               i2s_bclk_o,
	output logic               i2s_lrclk_o,
	output logic               i2s_dac_o,
	input  wire                i2s_adc_i
);

	logic               cnt_load;
	sys_pkg::wait_cnt_t cnt_value;
	logic               cnt_done;
	logic               ram_we;
	logic               ram_re;
	logic               io_we;
	sys_pkg::region_e   region;
	sys_pkg::word_t     ram_rdata;
	sys_pkg::word_t     io_rdata;
	logic               tx_en;
	logic               rx_en;
	sys_pkg::sample_t   dac_left;
	sys_pkg::sample_t   dac_right;
	sys_pkg::sample_t   adc_sample;
	logic               adc_valid;

	bus_sequencer #(.STACK_WAIT(STACK_WAIT)) u_bus_sequencer (
		.cpu_clk, .rst, .bus_stb_i, .bus_req_i, .bus_ack_o,
		.cnt_load_o(cnt_load), .cnt_value_o(cnt_value), .cnt_done_i(cnt_done),
		.ram_we_o(ram_we), .ram_re_o(ram_re), .io_we_o(io_we), .region_o(region)
	);

	wait_counter u_wait_counter (
		.cpu_clk, .rst, .load_i(cnt_load), .value_i(cnt_value), .done_o(cnt_done)
	);

	stack_ram #(.ADDR_W(STACK_ADDR_W)) u_stack_ram (
		.cpu_clk, .we_i(ram_we), .re_i(ram_re), .req_i(bus_req_i), .rdata_o(ram_rdata)
	);

	io_regs u_io_regs (
		.cpu_clk, .rst, .we_i(io_we), .region_i(region), .req_i(bus_req_i),
		.sw_i, .btn_i, .led_o, .tx_en_o(tx_en), .rx_en_o(rx_en),
		.dac_left_o(dac_left), .dac_right_o(dac_right),
		.adc_sample_i(adc_sample), .adc_valid_i(adc_valid), .rdata_o(io_rdata)
	);

	i2s_codec #(.BCLK_DIV(BCLK_DIV)) u_i2s_codec (
		.cpu_clk, .rst, .tx_en_i(tx_en), .rx_en_i(rx_en),
		.dac_left_i(dac_left), .dac_right_i(dac_right), .adc_i(i2s_adc_i),
		.bclk_o(i2s_bclk_o), .lrclk_o(i2s_lrclk_o), .dac_o(i2s_dac_o),
		.adc_sample_o(adc_sample), .adc_valid_o(adc_valid)
	);

	// Unmapped cycles read back as zero
	always_comb begin
		case (region)
			sys_pkg::REGION_STACK: bus_rdata_o = ram_rdata;
			sys_pkg::REGION_IO:    bus_rdata_o = io_rdata;
			default:               bus_rdata_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* design/stack_ram.sv */
// ==========================================================================
// On-chip stack RAM, one 16-bit word per even address
// Writes honour the byte lanes, reads return registered data
// ==========================================================================

`default_nettype none

module stack_ram #(
	parameter int ADDR_W = 10
) (
	input  wire                cpu_clk,
	input  wire                we_i,
	input  wire                re_i,
	input  sys_pkg::bus_req_t  req_i,
	output sys_pkg::word_t     rdata_o
);

	localparam int DEPTH = 1 << ADDR_W;

	sys_pkg::word_t mem [DEPTH];

	logic [ADDR_W-1:0] widx;

	// Bit 0 selects the byte, the word index sits above it
	assign widx = req_i.addr[ADDR_W:1];

	always_ff @(posedge cpu_clk) begin
		if (we_i) begin
			if (req_i.sel[1])
				mem[widx][15:8] <= req_i.wdata[15:8];
			if (req_i.sel[0])
				mem[widx][7:0] <= req_i.wdata[7:0];
		end
	end

	// Held until the next read
	always_ff @(posedge cpu_clk) begin
		if (re_i)
			rdata_o <= mem[widx];
	end

endmodule

`default_nettype wire

/* design/wait_counter.sv */
// ==========================================================================
// Wait-state down-counter, loaded by the sequencer at the start of a
// stretched access; done goes high once the count has run out
// ==========================================================================

`default_nettype none

module wait_counter (
	input  wire                 cpu_clk,
	input  wire                 rst,
	input  wire                 load_i,
	input  sys_pkg::wait_cnt_t  value_i,
	output logic                done_o
);

	sys_pkg::wait_cnt_t count_q;

	always_ff @(posedge cpu_clk) begin
		if (rst) begin
			count_q <= '0;
		end else if (load_i) begin
			count_q <= value_i;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
		end
	end

	// A pending load hides a stale zero
	assign done_o = (count_q == '0) && !load_i;

endmodule

`default_nettype wire

/* periph_sys.f */
common/sys_pkg.sv
design/bus_sequencer.sv
design/wait_counter.sv
design/stack_ram.sv
design/io_regs.sv
audio/i2s_codec.sv
design/periph_sys.sv
tb/periph_sys_tb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
	--top-module periph_sys_tb \
	-f periph_sys.f \
	--Mdir obj_dir \
	-o periph_sys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/periph_sys_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit $status
fi

exit 0

/* tb/periph_sys_tb.sv */
// ==========================================================================
// Testbench for the peripheral subsystem: drives bus cycles into the
// stack RAM, the I/O registers and unmapped space, and checks the I2S
// codec serial stream with the DAC output looped back to the ADC input
// ==========================================================================

`default_nettype none

module periph_sys_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int STACK_WAIT   = 2;
	localparam int STACK_ADDR_W = 10;
	localparam int BCLK_DIV     = 2;
	localparam int RESET_CYCLES = 16;
	localparam int ACK_LIMIT    = 20;
	localparam int STACK_WORDS  = 64;
	localparam int RAND_WRITES  = 200;
	localparam int UNMAP_OPS    = 40;
	localparam int OTHER_OPS    = 40;
	localparam int NUM_OPS      = 2 * STACK_WORDS + RAND_WRITES + UNMAP_OPS + OTHER_OPS;
	localparam int FRAME_BITS   = 64;
	localparam int FRAME_CYCLES = FRAME_BITS * 2 * BCLK_DIV;
	localparam int AUDIO_FRAMES = 2;
	localparam int LIMIT_CYCLES = RESET_CYCLES + NUM_OPS * 40 + (AUDIO_FRAMES + 1) * FRAME_CYCLES;

	logic               cpu_clk;
	logic               rst;
	logic               bus_stb_i;
	sys_pkg::bus_req_t  bus_req_i;
	logic               bus_ack_o;
	sys_pkg::word_t     bus_rdata_o;
	logic [7:0]         sw_i;
	logic [2:0]         btn_i;
	logic [7:0]         led_o;
	logic               i2s_bclk_o;
	logic               i2s_lrclk_o;
	logic               i2s_dac_o;
	logic               i2s_adc_i;

	// Expected state of the memory map
	sys_pkg::word_t     stack_shadow [1 << STACK_ADDR_W];
	logic [7:0]         led_exp;
	logic [1:0]         aud_exp;
	sys_pkg::sample_t   dac_l_exp;
	sys_pkg::sample_t   dac_r_exp;
	sys_pkg::sample_t   adc_exp;

	integer             seed;
	logic [31:0]        rnd;
	sys_pkg::addr_t     cur_addr;
	logic               cur_read;
	int                 ops;
	int                 ack_count;
	int                 i;
	logic               loop_en;
	logic               dac_seen;

	periph_sys #(
		.STACK_WAIT(STACK_WAIT), .STACK_ADDR_W(STACK_ADDR_W), .BCLK_DIV(BCLK_DIV)
	) u_periph_sys (
		.cpu_clk(cpu_clk), .rst(rst), .bus_stb_i(bus_stb_i), .bus_req_i(bus_req_i),
		.bus_ack_o(bus_ack_o), .bus_rdata_o(bus_rdata_o), .sw_i(sw_i), .btn_i(btn_i),
		.led_o(led_o), .i2s_bclk_o(i2s_bclk_o), .i2s_lrclk_o(i2s_lrclk_o),
		.i2s_dac_o(i2s_dac_o), .i2s_adc_i(i2s_adc_i)
	);

	always #5 cpu_clk = ~cpu_clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "stopping on the first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp_v,
	                           input logic [31:0] got_v);
		if (exp_v !== got_v)
			fail_run($sformatf("error %s exp %h got %h", name, exp_v, got_v));
	endtask

	// Memory map model, unmapped space reads as zero
	function automatic sys_pkg::word_t ref_read(input sys_pkg::addr_t addr);
		sys_pkg::word_t r;
		r = '0;
		if (addr[31:20] == 12'hFF4) begin
			r = stack_shadow[addr[STACK_ADDR_W:1]];
		end else if (addr[31:4] == 28'hFFDC060) begin
			case (addr[3:0])
				sys_pkg::IO_LED:      r = {8'h00, led_exp};
				sys_pkg::IO_SW:       r = {8'h00, sw_i};
				sys_pkg::IO_AUD_CTRL: r = {14'h0000, aud_exp};
				sys_pkg::IO_DAC_L:    r = dac_l_exp;
				sys_pkg::IO_DAC_R:    r = dac_r_exp;
				sys_pkg::IO_ADC:      r = adc_exp;
				default:              r = '0;
			endcase
		end
		return r;
	endfunction

	function automatic logic [15:0] lane_merge(input logic [15:0] old_v,
	                                          input logic [15:0] new_v, input logic [1:0] sel);
		return {sel[1] ? new_v[15:8] : old_v[15:8], sel[0] ? new_v[7:0] : old_v[7:0]};
	endfunction

	function automatic logic [7:0] led_ref(input logic [2:0] btn, input sys_pkg::addr_t addr);
		return btn[2] ? addr[23:16] : btn[1] ? addr[15:8] : btn[0] ? addr[7:0] : led_exp;
	endfunction

	task automatic apply_write(input sys_pkg::bus_req_t req);
		if (req.addr[31:20] == 12'hFF4) begin
			stack_shadow[req.addr[STACK_ADDR_W:1]] =
				lane_merge(stack_shadow[req.addr[STACK_ADDR_W:1]], req.wdata, req.sel);
		end else if (req.addr[31:4] == 28'hFFDC060) begin
			case (req.addr[3:0])
				sys_pkg::IO_LED:      if (req.sel[0]) led_exp = req.wdata[7:0];
				sys_pkg::IO_AUD_CTRL: if (req.sel[0]) aud_exp = req.wdata[1:0];
				sys_pkg::IO_DAC_L:    dac_l_exp = lane_merge(dac_l_exp, req.wdata, req.sel);
				sys_pkg::IO_DAC_R:    dac_r_exp = lane_merge(dac_r_exp, req.wdata, req.sel);
				default: ;
			endcase
		end
	endtask

	// One strobe, held until the acknowledge
	task automatic bus_cycle(input sys_pkg::addr_t addr, input sys_pkg::word_t wdata,
	                         input logic we, input sys_pkg::sel_t sel);
		sys_pkg::bus_req_t req;
		int waited;
		req.addr  = addr;
		req.wdata = wdata;
		req.we    = we;
		req.sel   = sel;
		waited    = 0;
		@(posedge cpu_clk);
		cur_addr = addr;
		cur_read = !we;
		ops      = ops + 1;
		bus_stb_i <= 1'b1;
		bus_req_i <= req;
		@(negedge cpu_clk);
		while (!bus_ack_o) begin
			waited = waited + 1;
			if (waited >= ACK_LIMIT)
				fail_run($sformatf("no acknowledge within %0d cycles for address %h",
				                   ACK_LIMIT, addr));
			@(negedge cpu_clk);
		end
		if (we)
			apply_write(req);
		@(posedge cpu_clk);
		bus_stb_i <= 1'b0;
	endtask

	task automatic bus_read(input sys_pkg::addr_t addr);
		bus_cycle(addr, 16'h0000, 1'b0, 2'b11);
	endtask

	// Read data and acknowledge count, checked in the acknowledge cycle
	always @(negedge cpu_clk) begin
		if (bus_ack_o) begin
			ack_count = ack_count + 1;
			if (cur_read)
				check_value("bus_rdata_o", {16'h0000, ref_read(cur_addr)}, {16'h0000, bus_rdata_o});
		end
	end

	// DAC to ADC loopback
	always @(negedge cpu_clk)
		dac_seen = i2s_dac_o;
	always @(posedge cpu_clk)
		i2s_adc_i <= loop_en & dac_seen;

	// Checks dac, lrclk and the bit period at every rising bit clock
	task automatic check_frames(input int n_bits);
		int k;
		int cycles;
		int slot;
		int last_rise;
		logic bclk_prev;
		logic exp_bit;
		sys_pkg::sample_t s;
		k = 0;
		cycles = 0;
		last_rise = -1;
		@(negedge cpu_clk);
		bclk_prev = i2s_bclk_o;
		while (k < n_bits) begin
			@(negedge cpu_clk);
			cycles = cycles + 1;
			if (cycles > n_bits * 2 * BCLK_DIV + 32)
				fail_run("the bit clock stopped before the frames were complete");
			if (i2s_bclk_o && !bclk_prev) begin
				if (last_rise >= 0)
					check_value("i2s_bclk_o period", 32'(2 * BCLK_DIV),
					            32'(cycles - last_rise));
				last_rise = cycles;
				slot = k % 32;
				s = ((k / 32) % 2 != 0) ? dac_r_exp : dac_l_exp;
				exp_bit = (slot >= 1 && slot <= 16) ? s[16 - slot] : 1'b0;
				check_value("i2s_lrclk_o", 32'((k / 32) % 2), {31'h0, i2s_lrclk_o});
				check_value("i2s_dac_o", {31'h0, exp_bit}, {31'h0, i2s_dac_o});
				k = k + 1;
			end
			bclk_prev = i2s_bclk_o;
		end
	endtask

	task automatic check_pins_low(input int n_cycles);
		repeat (n_cycles) begin
			@(negedge cpu_clk);
			check_value("i2s_bclk_o", 32'h0, {31'h0, i2s_bclk_o});
			check_value("i2s_lrclk_o", 32'h0, {31'h0, i2s_lrclk_o});
			check_value("i2s_dac_o", 32'h0, {31'h0, i2s_dac_o});
		end
	endtask

	initial begin
		#(LIMIT_CYCLES * 10);
		fail_run("watchdog expired, the run did not finish in time");
	end

	initial begin
		cpu_clk   = 1'b0;
		rst       = 1'b1;
		bus_stb_i = 1'b0;
		bus_req_i = '0;
		sw_i      = 8'h00;
		btn_i     = 3'b000;
		i2s_adc_i = 1'b0;
		loop_en   = 1'b0;
		dac_seen  = 1'b0;
		seed      = 32'h195225f5;
		ops       = 0;
		ack_count = 0;
		cur_read  = 1'b0;
		cur_addr  = '0;
		led_exp   = 8'h00;
		aud_exp   = 2'b00;
		dac_l_exp = '0;
		dac_r_exp = '0;
		adc_exp   = '0;
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		rst <= 1'b0;

		// Reset state
		check_pins_low(16);
		check_value("led_o", 32'h0, {24'h0, led_o});
		bus_read(32'hFFDC_0604);
		bus_read(32'hFFDC_0606);
		bus_read(32'hFFDC_0608);

		// Stack RAM, full words first so every lane is known
		for (i = 0; i < STACK_WORDS; i++) begin
			rnd = $random(seed);
			bus_cycle({20'hFF400, 5'h00, 6'(i), 1'b0}, rnd[15:0], 1'b1, 2'b11);
		end
		for (i = 0; i < RAND_WRITES; i++) begin
			rnd = $random(seed);
			bus_cycle({20'hFF400, 5'h00, rnd[5:0], 1'b0}, rnd[31:16], 1'b1, rnd[7:6]);
		end
		for (i = 0; i < STACK_WORDS; i++)
			bus_read({20'hFF400, 5'h00, 6'(i), 1'b0});

		// LED, switches and the button display
		rnd = $random(seed);
		bus_cycle(32'hFFDC_0600, {8'h00, rnd[7:0]}, 1'b1, 2'b11);
		@(negedge cpu_clk);
		check_value("led_o", {24'h0, led_exp}, {24'h0, led_o});
		bus_read(32'hFFDC_0600);
		@(posedge cpu_clk);
		sw_i <= rnd[15:8];
		bus_read(32'hFFDC_0602);
		for (i = 0; i < 8; i++) begin
			@(posedge cpu_clk);
			btn_i <= 3'(i);
			@(negedge cpu_clk);
			check_value("led_o", {24'h0, led_ref(3'(i), cur_addr)}, {24'h0, led_o});
		end
		@(posedge cpu_clk);
		btn_i <= 3'b000;

		// Unmapped space and unused I/O offsets
		for (i = 0; i < 16; i++) begin
			rnd = $random(seed);
			bus_read({1'b0, rnd[30:1], 1'b0});
			rnd = $random(seed);
			bus_cycle({1'b0, rnd[30:0]}, rnd[15:0], 1'b1, rnd[17:16]);
		end
		bus_cycle(32'hFFDC_0610, 16'hFFFF, 1'b1, 2'b11);
		bus_cycle(32'hFF50_0000, 16'hFFFF, 1'b1, 2'b11);
		bus_read(32'hFFDC_0610);
		bus_read(32'hFF50_0000);
		bus_read(32'hFFDC_060C);
		bus_read(32'hFFDC_060E);
		for (i = 0; i < 8; i++)
			bus_read({20'hFF400, 5'h00, 6'(i * 7), 1'b0});
		bus_read(32'hFFDC_0600);
		@(negedge cpu_clk);
		check_value("led_o", {24'h0, led_exp}, {24'h0, led_o});

		// Codec with loopback over two frames
		rnd = $random(seed);
		bus_cycle(32'hFFDC_0606, rnd[15:0], 1'b1, 2'b11);
		bus_cycle(32'hFFDC_0608, rnd[31:16], 1'b1, 2'b11);
		loop_en = 1'b1;
		bus_cycle(32'hFFDC_0604, 16'h0003, 1'b1, 2'b01);
		check_frames(AUDIO_FRAMES * FRAME_BITS);
		adc_exp = dac_l_exp;
		bus_read(32'hFFDC_060A);
		bus_read(32'hFFDC_0604);
		bus_cycle(32'hFFDC_0604, 16'h0000, 1'b1, 2'b01);
		check_pins_low(8);

		@(negedge cpu_clk);
		check_value("ack count", 32'(ops), 32'(ack_count));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire
